/* project.f */
common/cpu_types_pkg.sv
decode/control_unit.sv
decode/register_file.sv
decode/decode_stage.sv
rtl/decode_execute_latch.sv
rtl/execute_stage.sv
rtl/datapath_slice.sv
dv/datapath_slice_tb.sv

/* Bender.yml */
package:
  name: datapath_slice

sources:
  - files:
      - common/cpu_types_pkg.sv
      - decode/control_unit.sv
      - decode/register_file.sv
      - decode/decode_stage.sv
      - rtl/decode_execute_latch.sv
      - rtl/execute_stage.sv
      - rtl/datapath_slice.sv
  - target: test
    files:
      - dv/datapath_slice_tb.sv

/* dv/datapath_slice_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath_slice_tb import cpu_types_pkg::*; ();

	typedef struct packed {
		word_t      alu;
		word_t      store;
		word_t      target;
		logic       rw;
		logic       ren;
		logic       wen;
		logic       halt;
		regbits_t   wsel;
		logic [1:0] m2r;
		logic [2:0] pcs;
		logic       chk_alu;
		logic       chk_store;
		logic       chk_wsel;
		logic       chk_m2r;
		logic       chk_target;
	} expect_t;

	localparam logic [59:0] alu_functs = {SLL, SRL, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU};
	localparam logic [29:0] imm_ops    = {ADDIU, SLTI, ANDI, ORI, XORI};

	logic      CLK;
	logic      nRST;
	word_t     imemload;
	word_t     NPC;
	logic      wb_wen;
	regbits_t  wb_wsel;
	word_t     wb_wdat;
	word_t     alu_result;
	word_t     store_data;
	logic      dmem_ren;
	logic      dmem_wen;
	logic      regwrite;
	regbits_t  wsel;
	memtoreg_t memtoreg;
	pcselect_t pc_select;
	word_t     pc_target;
	logic      halt;

	// register contents as the model sees them
	word_t   shadow [32];
	// outputs due for the instruction now in the latch
	expect_t cur;
	word_t   lfsr = 32'd24630;

	datapath_slice UUT (
		.CLK        (CLK),
		.nRST       (nRST),
		.imemload   (imemload),
		.NPC        (NPC),
		.wb_wen     (wb_wen),
		.wb_wsel    (wb_wsel),
		.wb_wdat    (wb_wdat),
		.alu_result (alu_result),
		.store_data (store_data),
		.dmem_ren   (dmem_ren),
		.dmem_wen   (dmem_wen),
		.regwrite   (regwrite),
		.wsel       (wsel),
		.memtoreg   (memtoreg),
		.pc_select  (pc_select),
		.pc_target  (pc_target),
		.halt       (halt)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#20 CLK = ~CLK;
		end
	end

	// galois lfsr, one step per bit
	function automatic word_t random_bits(input int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// only the preloaded registers
	function automatic regbits_t pick_reg();
		return regbits_t'(random_bits(4) % 10);
	endfunction

	function automatic word_t encode_r(input logic [5:0] fn, input regbits_t rs,
	                                   input regbits_t rt, input regbits_t rd,
	                                   input logic [4:0] shamt);
		return {RTYPE, rs, rt, rd, shamt, fn};
	endfunction

	function automatic word_t encode_i(input logic [5:0] op, input regbits_t rs,
	                                   input regbits_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t encode_j(input logic [5:0] op, input logic [25:0] index);
		return {op, index};
	endfunction

	function automatic expect_t rt_result(input expect_t e, input word_t instr,
	                                      input word_t alu);
		expect_t r;
		r = e;
		r.alu = alu;
		r.chk_alu = 1'b1;
		r.rw = 1'b1;
		r.wsel = instr[20:16];
		r.chk_wsel = 1'b1;
		r.chk_m2r = 1'b1;
		return r;
	endfunction

	function automatic expect_t predict(input word_t instr, input word_t npc);
		expect_t e;
		word_t   a;
		word_t   b;
		word_t   sext;
		word_t   zext;
		a = shadow[instr[25:21]];
		b = shadow[instr[20:16]];
		sext = {{16{instr[15]}}, instr[15:0]};
		zext = {16'h0000, instr[15:0]};
		e = '0;
		e.m2r = FROM_ALU;
		e.pcs = SEQUENTIAL;
		case (instr[31:26])
			RTYPE: begin
				e.rw = 1'b1;
				e.wsel = instr[15:11];
				e.chk_wsel = 1'b1;
				e.chk_alu = 1'b1;
				e.chk_m2r = 1'b1;
				case (instr[5:0])
					SLL:  e.alu = b << instr[10:6];
					SRL:  e.alu = b >> instr[10:6];
					ADDU: e.alu = a + b;
					SUBU: e.alu = a - b;
					AND:  e.alu = a & b;
					OR:   e.alu = a | b;
					XOR:  e.alu = a ^ b;
					NOR:  e.alu = ~(a | b);
					SLT:  e.alu = {31'b0, $signed(a) < $signed(b)};
					SLTU: e.alu = {31'b0, a < b};
					JR: begin
						e = '0;
						e.pcs = REGISTER;
						e.target = a;
						e.chk_target = 1'b1;
					end
					default: ;
				endcase
			end
			ADDIU: e = rt_result(e, instr, a + sext);
			SLTI:  e = rt_result(e, instr, {31'b0, $signed(a) < $signed(sext)});
			ANDI:  e = rt_result(e, instr, a & zext);
			ORI:   e = rt_result(e, instr, a | zext);
			XORI:  e = rt_result(e, instr, a ^ zext);
			LUI:   e = rt_result(e, instr, {instr[15:0], 16'h0000});
			LW: begin
				e = rt_result(e, instr, a + sext);
				e.ren = 1'b1;
				e.m2r = FROM_MEM;
			end
			SW: begin
				e.alu = a + sext;
				e.chk_alu = 1'b1;
				e.wen = 1'b1;
				e.store = b;
				e.chk_store = 1'b1;
			end
			BEQ, BNE: begin
				// beq wants equal operands, bne unequal
				if ((a == b) == (instr[31:26] == BEQ)) begin
					e.pcs = BRANCH;
					e.target = npc + (sext << 2);
					e.chk_target = 1'b1;
				end
			end
			J, JAL: begin
				e.pcs = JUMP;
				e.target = {npc[31:28], instr[25:0], 2'b00};
				e.chk_target = 1'b1;
				if (instr[31:26] == JAL) begin
					e.rw = 1'b1;
					e.wsel = 5'd31;
					e.chk_wsel = 1'b1;
					e.m2r = FROM_NPC;
					e.chk_m2r = 1'b1;
				end
			end
			HALT: e.halt = 1'b1;
			default: ;
		endcase
		return e;
	endfunction

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		assert (actual === expected) else begin
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic check_outputs(input expect_t e);
		check_value("regwrite", e.rw, regwrite);
		check_value("dmem_ren", e.ren, dmem_ren);
		check_value("dmem_wen", e.wen, dmem_wen);
		check_value("halt", e.halt, halt);
		check_value("pc_select", e.pcs, pc_select);
		if (e.chk_alu) check_value("alu_result", e.alu, alu_result);
		if (e.chk_store) check_value("store_data", e.store, store_data);
		if (e.chk_wsel) check_value("wsel", e.wsel, wsel);
		if (e.chk_m2r) check_value("memtoreg", e.m2r, memtoreg);
		if (e.chk_target) check_value("pc_target", e.target, pc_target);
	endtask

	// drive one cycle, then check the instruction already in the latch
	task automatic step(input word_t instr, input word_t npc, input logic wen,
	                    input regbits_t wreg, input word_t wdat);
		expect_t nxt;
		@(posedge CLK);
		#2;
		imemload = instr;
		NPC = npc;
		wb_wen = wen;
		wb_wsel = wreg;
		wb_wdat = wdat;
		nxt = predict(instr, npc);
		if (wen && wreg != '0) begin
			shadow[wreg] = wdat;
		end
		#36;
		check_outputs(cur);
		cur = nxt;
	endtask

	task automatic issue(input word_t instr);
		step(instr, random_bits(32), 1'b0, '0, '0);
	endtask

	task automatic preload(input regbits_t r, input word_t data);
		step('0, '0, 1'b1, r, data);
		step('0, '0, 1'b0, '0, '0);
	endtask

	task automatic wait_for_halt(input int limit);
		int cycles;
		cycles = 0;
		while (halt !== 1'b1) begin
			if (cycles == limit) begin
				$display("timeout: halt did not rise within %0d cycles", limit);
				$display("Test failed");
				$fatal(1);
			end
			@(posedge CLK);
			#38;
			cycles++;
		end
	endtask

	initial begin
		regbits_t rs;
		nRST = 1'b0;
		imemload = '0;
		NPC = '0;
		wb_wen = 1'b0;
		wb_wsel = '0;
		wb_wdat = '0;
		for (int r = 0; r < 32; r++) begin
			shadow[r] = '0;
		end
		repeat (5) @(posedge CLK);
		#2;
		nRST = 1'b1;
		// latch stays cleared until the next edge
		#36;
		check_outputs('0);
		cur = predict('0, '0);

		// register 0 is written too, must still read zero
		for (int r = 0; r < 10; r++) begin
			preload(regbits_t'(r), random_bits(32));
		end

		for (int i = 0; i < 10; i++) begin
			issue(encode_r(alu_functs[i*6 +: 6], pick_reg(), pick_reg(),
			               regbits_t'(random_bits(5)), 5'(random_bits(5))));
		end
		issue(encode_r(ADDU, 5'd0, 5'd3, 5'd12, 5'd0));
		issue(encode_r(OR, 5'd0, 5'd0, 5'd13, 5'd0));

		// top immediate bit set so sign and zero extension differ
		for (int i = 0; i < 5; i++) begin
			issue(encode_i(imm_ops[i*6 +: 6], pick_reg(), pick_reg(),
			               {1'b1, 15'(random_bits(15))}));
		end
		issue(encode_i(LUI, 5'd0, pick_reg(), 16'(random_bits(16))));
		issue(encode_i(LW, pick_reg(), pick_reg(), {1'b1, 15'(random_bits(15))}));
		issue(encode_i(SW, pick_reg(), pick_reg(), 16'(random_bits(16))));

		rs = pick_reg();
		issue(encode_i(BEQ, rs, rs, 16'(random_bits(16))));
		issue(encode_i(BEQ, 5'd1, 5'd2, 16'(random_bits(16))));
		issue(encode_i(BNE, rs, rs, 16'(random_bits(16))));
		issue(encode_i(BNE, 5'd1, 5'd2, 16'(random_bits(16))));
		issue(encode_j(J, 26'(random_bits(26))));
		issue(encode_j(JAL, 26'(random_bits(26))));
		issue(encode_r(JR, pick_reg(), 5'd0, 5'd0, 5'd0));
		issue(encode_j(HALT, '0));

		wait_for_halt(4);
		check_outputs(cur);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/datapath_slice.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath_slice import cpu_types_pkg::*; (
	input  logic      CLK,
	input  logic      nRST,
	input  word_t     imemload,
	input  word_t     NPC,
	input  logic      wb_wen,
	input  regbits_t  wb_wsel,
	input  word_t     wb_wdat,
	output word_t     alu_result,
	output word_t     store_data,
	output logic      dmem_ren,
	output logic      dmem_wen,
	output logic      regwrite,
	output regbits_t  wsel,
	output memtoreg_t memtoreg,
	output pcselect_t pc_select,
	output word_t     pc_target,
	output logic      halt
);

	// decode side
	alusrc_t   alusrc_id;
	memtoreg_t memtoreg_id;
	logic      signzero_id;
	aluop_t    aluop_id;
	logic      regwrite_id;
	pcselect_t pcselect_id;
	regdst_t   regdst_id;
	logic      branch_id;
	logic      dmemren_id;
	logic      dmemwen_id;
	logic      halt_id;
	word_t     npc_id;
	word_t     rdat_one_id;
	word_t     rdat_two_id;
	word_t     upper_imm_id;
	word_t     signzero_imm_id;

	// execute side
	alusrc_t   alusrc_ex;
	memtoreg_t memtoreg_ex;
	logic      signzero_ex;
	aluop_t    aluop_ex;
	logic      regwrite_ex;
	pcselect_t pcselect_ex;
	regdst_t   regdst_ex;
	logic      branch_ex;
	logic      dmemren_ex;
	logic      dmemwen_ex;
	logic      halt_ex;
	word_t     npc_ex;
	word_t     rdat_one_ex;
	word_t     rdat_two_ex;
	word_t     imemload_ex;
	word_t     upper_imm_ex;
	word_t     signzero_imm_ex;

	decode_stage u_decode (
		.CLK (CLK), .nRST (nRST),
		.imemload (imemload), .NPC (NPC),
		.wb_wen (wb_wen), .wb_wsel (wb_wsel), .wb_wdat (wb_wdat),
		.alusrc (alusrc_id), .memtoreg (memtoreg_id), .signzero (signzero_id),
		.aluop (aluop_id), .regwrite (regwrite_id), .pcselect (pcselect_id),
		.regdst (regdst_id), .branch (branch_id),
		.request_dmemren (dmemren_id), .request_dmemwen (dmemwen_id),
		.halt (halt_id), .npc (npc_id),
		.rdat_one (rdat_one_id), .rdat_two (rdat_two_id),
		.upper_imm (upper_imm_id), .signzero_imm (signzero_imm_id)
	);

	// instruction word enters the latch as fetched
	decode_execute_latch u_latch (
		.CLK (CLK), .nRST (nRST),
		.alusrc (alusrc_id), .memtoreg (memtoreg_id), .signzero (signzero_id),
		.aluop (aluop_id), .regwrite (regwrite_id), .pcselect (pcselect_id),
		.regdst (regdst_id), .branch (branch_id),
		.request_dmemren (dmemren_id), .request_dmemwen (dmemwen_id),
		.halt (halt_id), .npc (npc_id),
		.rdat_one (rdat_one_id), .rdat_two (rdat_two_id), .imemload (imemload),
		.upper_imm (upper_imm_id), .signzero_imm (signzero_imm_id),
		.alusrc_ex (alusrc_ex), .memtoreg_ex (memtoreg_ex), .signzero_ex (signzero_ex),
		.aluop_ex (aluop_ex), .regwrite_ex (regwrite_ex), .pcselect_ex (pcselect_ex),
		.regdst_ex (regdst_ex), .branch_ex (branch_ex),
		.request_dmemren_ex (dmemren_ex), .request_dmemwen_ex (dmemwen_ex),
		.halt_ex (halt_ex), .npc_ex (npc_ex),
		.rdat_one_ex (rdat_one_ex), .rdat_two_ex (rdat_two_ex),
		.imemload_ex (imemload_ex),
		.upper_imm_ex (upper_imm_ex), .signzero_imm_ex (signzero_imm_ex)
	);

	execute_stage u_execute (
		.alusrc_ex (alusrc_ex), .memtoreg_ex (memtoreg_ex), .signzero_ex (signzero_ex),
		.aluop_ex (aluop_ex), .regwrite_ex (regwrite_ex), .pcselect_ex (pcselect_ex),
		.regdst_ex (regdst_ex), .branch_ex (branch_ex),
		.request_dmemren_ex (dmemren_ex), .request_dmemwen_ex (dmemwen_ex),
		.halt_ex (halt_ex), .npc_ex (npc_ex),
		.rdat_one_ex (rdat_one_ex), .rdat_two_ex (rdat_two_ex),
		.imemload_ex (imemload_ex),
		.upper_imm_ex (upper_imm_ex), .signzero_imm_ex (signzero_imm_ex),
		.alu_result (alu_result), .store_data (store_data),
		.dmem_ren (dmem_ren), .dmem_wen (dmem_wen),
		.regwrite (regwrite), .wsel (wsel), .memtoreg (memtoreg),
		.pcselect (pc_select), .pc_target (pc_target), .halt (halt)
	);

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_types_pkg::*; (
	input  alusrc_t   alusrc_ex,
	input  memtoreg_t memtoreg_ex,
	input  logic      signzero_ex,
	input  aluop_t    aluop_ex,
	input  logic      regwrite_ex,
	input  pcselect_t pcselect_ex,
	input  regdst_t   regdst_ex,
	input  logic      branch_ex,
	input  logic      request_dmemren_ex,
	input  logic      request_dmemwen_ex,
	input  logic      halt_ex,
	input  word_t     npc_ex,
	input  word_t     rdat_one_ex,
	input  word_t     rdat_two_ex,
	input  word_t     imemload_ex,
	input  word_t     upper_imm_ex,
	input  word_t     signzero_imm_ex,
	output word_t     alu_result,
	output word_t     store_data,
	output logic      dmem_ren,
	output logic      dmem_wen,
	output logic      regwrite,
	output regbits_t  wsel,
	output memtoreg_t memtoreg,
	output pcselect_t pcselect,
	output word_t     pc_target,
	output logic      halt
);

	word_t          alu_a;
	word_t          alu_b;
	logic [4:0]     shamt;
	word_t          branch_off;
	logic           taken;

	assign alu_a = rdat_one_ex;
	assign shamt = imemload_ex[10:6];

	always_comb begin
		case (alusrc_ex)
			SIGNZERO_IMM: alu_b = signzero_imm_ex;
			UPPER_IMM:    alu_b = upper_imm_ex;
			default:      alu_b = rdat_two_ex;
		endcase
	end

	always_comb begin
		case (aluop_ex)
			ALU_SLL:  alu_result = rdat_two_ex << shamt;
			ALU_SRL:  alu_result = rdat_two_ex >> shamt;
			ALU_ADD:  alu_result = alu_a + alu_b;
			ALU_SUB:  alu_result = alu_a - alu_b;
			ALU_AND:  alu_result = alu_a & alu_b;
			ALU_OR:   alu_result = alu_a | alu_b;
			ALU_XOR:  alu_result = alu_a ^ alu_b;
			ALU_NOR:  alu_result = ~(alu_a | alu_b);
			ALU_SLT:  alu_result = {{(WORD_W-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
			ALU_SLTU: alu_result = {{(WORD_W-1){1'b0}}, alu_a < alu_b};
			default:  alu_result = '0;
		endcase
	end

	// branch offset is always signed
	assign branch_off = {{(WORD_W-IMM_W){imemload_ex[IMM_W-1]}}, imemload_ex[IMM_W-1:0]};

	// beq when branch is set, bne otherwise
	assign taken    = branch_ex ? (rdat_one_ex == rdat_two_ex) : (rdat_one_ex != rdat_two_ex);
	assign pcselect = (pcselect_ex == BRANCH && !taken) ? SEQUENTIAL : pcselect_ex;

	always_comb begin
		case (pcselect)
			BRANCH:   pc_target = npc_ex + (branch_off << 2);
			JUMP:     pc_target = {npc_ex[31:28], imemload_ex[ADDR_W-1:0], 2'b00};
			REGISTER: pc_target = rdat_one_ex;
			default:  pc_target = npc_ex;
		endcase
	end

	always_comb begin
		case (regdst_ex)
			RT:      wsel = imemload_ex[20:16];
			RA:      wsel = 5'd31;
			default: wsel = imemload_ex[15:11];
		endcase
	end

	assign store_data = rdat_two_ex;
	assign dmem_ren   = request_dmemren_ex;
	assign dmem_wen   = request_dmemwen_ex;
	assign regwrite   = regwrite_ex;
	assign memtoreg   = memtoreg_ex;
	assign halt       = halt_ex;

endmodule

`default_nettype wire

/* rtl/decode_execute_latch.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_execute_latch import cpu_types_pkg::*; (
	input  logic      CLK,
	input  logic      nRST,
	input  alusrc_t   alusrc,
	input  memtoreg_t memtoreg,
	input  logic      signzero,
	input  aluop_t    aluop,
	input  logic      regwrite,
	input  pcselect_t pcselect,
	input  regdst_t   regdst,
	input  logic      branch,
	input  logic      request_dmemren,
	input  logic      request_dmemwen,
	input  logic      halt,
	input  word_t     npc,
	input  word_t     rdat_one,
	input  word_t     rdat_two,
	input  word_t     imemload,
	input  word_t     upper_imm,
	input  word_t     signzero_imm,
	output alusrc_t   alusrc_ex,
	output memtoreg_t memtoreg_ex,
	output logic      signzero_ex,
	output aluop_t    aluop_ex,
	output logic      regwrite_ex,
	output pcselect_t pcselect_ex,
	output regdst_t   regdst_ex,
	output logic      branch_ex,
	output logic      request_dmemren_ex,
	output logic      request_dmemwen_ex,
	output logic      halt_ex,
	output word_t     npc_ex,
	output word_t     rdat_one_ex,
	output word_t     rdat_two_ex,
	output word_t     imemload_ex,
	output word_t     upper_imm_ex,
	output word_t     signzero_imm_ex
);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			// all-zero encodings, nothing writes or branches
			alusrc_ex          <= RDAT_TWO;
			memtoreg_ex        <= FROM_ALU;
			signzero_ex        <= 1'b0;
			aluop_ex           <= ALU_SLL;
			regwrite_ex        <= 1'b0;
			pcselect_ex        <= SEQUENTIAL;
			regdst_ex          <= RD;
			branch_ex          <= 1'b0;
			request_dmemren_ex <= 1'b0;
			request_dmemwen_ex <= 1'b0;
			halt_ex            <= 1'b0;
			npc_ex             <= '0;
			rdat_one_ex        <= '0;
			rdat_two_ex        <= '0;
			imemload_ex        <= '0;
			upper_imm_ex       <= '0;
			signzero_imm_ex    <= '0;
		end else begin
			alusrc_ex          <= alusrc;
			memtoreg_ex        <= memtoreg;
			signzero_ex        <= signzero;
			aluop_ex           <= aluop;
			regwrite_ex        <= regwrite;
			pcselect_ex        <= pcselect;
			regdst_ex          <= regdst;
			branch_ex          <= branch;
			request_dmemren_ex <= request_dmemren;
			request_dmemwen_ex <= request_dmemwen;
			halt_ex            <= halt;
			npc_ex             <= npc;
			rdat_one_ex        <= rdat_one;
			rdat_two_ex        <= rdat_two;
			imemload_ex        <= imemload;
			upper_imm_ex       <= upper_imm;
			signzero_imm_ex    <= signzero_imm;
		end
	end

endmodule

`default_nettype wire

/* decode/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_types_pkg::*; (
	input  logic      CLK,
	input  logic      nRST,
	input  word_t     imemload,
	input  word_t     NPC,
	input  logic      wb_wen,
	input  regbits_t  wb_wsel,
	input  word_t     wb_wdat,
	output alusrc_t   alusrc,
	output memtoreg_t memtoreg,
	output logic      signzero,
	output aluop_t    aluop,
	output logic      regwrite,
	output pcselect_t pcselect,
	output regdst_t   regdst,
	output logic      branch,
	output logic      request_dmemren,
	output logic      request_dmemwen,
	output logic      halt,
	output word_t     npc,
	output word_t     rdat_one,
	output word_t     rdat_two,
	output word_t     upper_imm,
	output word_t     signzero_imm
);

	logic [IMM_W-1:0] imm;

	assign imm = imemload[IMM_W-1:0];

	control_unit u_control (
		.imemload        (imemload),
		.alusrc          (alusrc),
		.memtoreg        (memtoreg),
		.signzero        (signzero),
		.aluop           (aluop),
		.regwrite        (regwrite),
		.pcselect        (pcselect),
		.regdst          (regdst),
		.branch          (branch),
		.request_dmemren (request_dmemren),
		.request_dmemwen (request_dmemwen),
		.halt            (halt)
	);

	// rs and rt fields
	register_file u_regs (
		.CLK      (CLK),
		.nRST     (nRST),
		.wen      (wb_wen),
		.wsel     (wb_wsel),
		.wdat     (wb_wdat),
		.rsel_one (imemload[25:21]),
		.rsel_two (imemload[20:16]),
		.rdat_one (rdat_one),
		.rdat_two (rdat_two)
	);

	assign signzero_imm = signzero ? {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm}
	                               : {{(WORD_W-IMM_W){1'b0}}, imm};
	assign upper_imm    = {imm, {(WORD_W-IMM_W){1'b0}}};
	assign npc          = NPC;

endmodule

`default_nettype wire

/* decode/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_types_pkg::*; (
	input  logic     CLK,
	input  logic     nRST,
	input  logic     wen,
	input  regbits_t wsel,
	input  word_t    wdat,
	input  regbits_t rsel_one,
	input  regbits_t rsel_two,
	output word_t    rdat_one,
	output word_t    rdat_two
);

	// register 0 has no storage
	word_t regs [2**REG_W-1:1];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 1; i < 2**REG_W; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (wsel != '0)) begin
			regs[wsel] <= wdat;
		end
	end

	// no write bypass, same-cycle reads see the old value
	assign rdat_one = (rsel_one == '0) ? '0 : regs[rsel_one];
	assign rdat_two = (rsel_two == '0) ? '0 : regs[rsel_two];

endmodule

`default_nettype wire

/* decode/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit import cpu_types_pkg::*; (
	input  word_t     imemload,
	output alusrc_t   alusrc,
	output memtoreg_t memtoreg,
	output logic      signzero,
	output aluop_t    aluop,
	output logic      regwrite,
	output pcselect_t pcselect,
	output regdst_t   regdst,
	output logic      branch,
	output logic      request_dmemren,
	output logic      request_dmemwen,
	output logic      halt
);

	opcode_t op;
	funct_t  fn;

	assign op = opcode_t'(imemload[31:26]);
	assign fn = funct_t'(imemload[5:0]);

	always_comb begin
		alusrc          = RDAT_TWO;
		memtoreg        = FROM_ALU;
		signzero        = 1'b0;
		aluop           = ALU_ADD;
		regwrite        = 1'b0;
		pcselect        = SEQUENTIAL;
		regdst          = RD;
		branch          = 1'b0;
		request_dmemren = 1'b0;
		request_dmemwen = 1'b0;
		halt            = 1'b0;
		case (op)
			RTYPE: begin
				regwrite = 1'b1;
				case (fn)
					SLL:  aluop = ALU_SLL;
					SRL:  aluop = ALU_SRL;
					ADDU: aluop = ALU_ADD;
					SUBU: aluop = ALU_SUB;
					AND:  aluop = ALU_AND;
					OR:   aluop = ALU_OR;
					XOR:  aluop = ALU_XOR;
					NOR:  aluop = ALU_NOR;
					SLT:  aluop = ALU_SLT;
					SLTU: aluop = ALU_SLTU;
					JR: begin
						regwrite = 1'b0;
						pcselect = REGISTER;
					end
					default: regwrite = 1'b0;
				endcase
			end
			J:   pcselect = JUMP;
			JAL: begin
				pcselect = JUMP;
				regwrite = 1'b1;
				regdst   = RA;
				memtoreg = FROM_NPC;
			end
			BEQ, BNE: begin
				pcselect = BRANCH;
				signzero = 1'b1;
				aluop    = ALU_SUB;
				branch   = (op == BEQ);
			end
			ADDIU, SLTI, ANDI, ORI, XORI: begin
				alusrc   = SIGNZERO_IMM;
				signzero = (op == ADDIU) || (op == SLTI);
				regwrite = 1'b1;
				regdst   = RT;
				case (op)
					SLTI:    aluop = ALU_SLT;
					ANDI:    aluop = ALU_AND;
					ORI:     aluop = ALU_OR;
					XORI:    aluop = ALU_XOR;
					default: aluop = ALU_ADD;
				endcase
			end
			// rs is zero in a lui, so or passes the immediate
			LUI: begin
				alusrc   = UPPER_IMM;
				aluop    = ALU_OR;
				regwrite = 1'b1;
				regdst   = RT;
			end
			LW, SW: begin
				alusrc          = SIGNZERO_IMM;
				signzero        = 1'b1;
				regwrite        = (op == LW);
				regdst          = RT;
				memtoreg        = FROM_MEM;
				request_dmemren = (op == LW);
				request_dmemwen = (op == SW);
			end
			HALT: halt = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* common/cpu_types_pkg.sv */
`default_nettype none

package cpu_types_pkg;

	// instruction field widths
	parameter int WORD_W = 32;
	parameter int REG_W  = 5;
	parameter int OP_W   = 6;
	parameter int FUNC_W = 6;
	parameter int IMM_W  = 16;
	parameter int ADDR_W = 26;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_W-1:0]  regbits_t;

	typedef enum logic [OP_W-1:0] {
		RTYPE = 6'h00,
		J     = 6'h02,
		JAL   = 6'h03,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDIU = 6'h09,
		SLTI  = 6'h0A,
		ANDI  = 6'h0C,
		ORI   = 6'h0D,
		XORI  = 6'h0E,
		LUI   = 6'h0F,
		LW    = 6'h23,
		SW    = 6'h2B,
		HALT  = 6'h3F
	} opcode_t;

	typedef enum logic [FUNC_W-1:0] {
		SLL  = 6'h00,
		SRL  = 6'h02,
		JR   = 6'h08,
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		NOR  = 6'h27,
		SLT  = 6'h2A,
		SLTU = 6'h2B
	} funct_t;

	typedef enum logic [3:0] {
		ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND,
		ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
	} aluop_t;

	typedef enum logic [1:0] {RDAT_TWO, SIGNZERO_IMM, UPPER_IMM} alusrc_t;

	// RA is register 31
	typedef enum logic [1:0] {RD, RT, RA} regdst_t;

	typedef enum logic [1:0] {FROM_ALU, FROM_MEM, FROM_NPC} memtoreg_t;

	typedef enum logic [2:0] {SEQUENTIAL, BRANCH, JUMP, REGISTER} pcselect_t;

endpackage

`default_nettype wire
